// File: cache_pkg.sv
//------------------------------------------------------------
// Shared widths and encodings for the two-way blocking cache.
// 16-byte lines; the tag keeps all address bits above offset
//------------------------------------------------------------
`default_nettype none

package cache_pkg;

  localparam int OFFSET_BITS      = 4;  // Byte offset within a line
  localparam int DEFAULT_NUM_SETS = 8;

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0]  wben_t;  // One bit per byte of a line

  // Upper address kept whole, so the index width never changes it
  typedef logic [$bits(addr_t)-OFFSET_BITS-1:0] tag_t;

  // Request encoding shared by the cache and memory ports
  typedef logic [2:0] req_type_t;
  localparam req_type_t REQ_READ  = 3'd0;
  localparam req_type_t REQ_WRITE = 3'd1;

  typedef enum logic [3:0] {
    idle,
    tag_check,
    read_access,
    write_access,
    evict_prepare,
    evict_request,
    evict_wait,
    refill_request,
    refill_wait,
    refill_update,
    wait_resp
  } cache_state_t;

endpackage

`default_nettype wire

// File: cache_ctrl_if.sv
//------------------------------------------------------------
// Control and status between cache controller and datapath
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface cache_ctrl_if #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS
);

  localparam int INDEX_BITS = $clog2(num_sets);

  // Controller to datapath
  logic                   req_reg_en;
  logic                   memresp_reg_en;
  logic                   write_data_sel;     // 1 selects the refill line
  logic                   tag_ren;
  logic                   tag_wen;
  logic                   data_ren;
  logic                   data_wen;
  cache_pkg::wben_t       data_wben;
  logic                   read_data_reg_en;
  logic                   evict_addr_reg_en;
  logic                   memreq_addr_sel;    // 1 selects the evict line
  logic [1:0]             way_wen;
  logic                   way_sel;

  // Datapath to controller
  logic [1:0]             tag_match;
  logic [INDEX_BITS-1:0]  req_index;
  logic [cache_pkg::OFFSET_BITS-3:0] req_word;
  cache_pkg::req_type_t   req_type;

  modport ctrl (
    output req_reg_en, memresp_reg_en, write_data_sel, tag_ren, tag_wen,
           data_ren, data_wen, data_wben, read_data_reg_en, evict_addr_reg_en,
           memreq_addr_sel, way_wen, way_sel,
    input  tag_match, req_index, req_word, req_type
  );

  modport dpath (
    input  req_reg_en, memresp_reg_en, write_data_sel, tag_ren, tag_wen,
           data_ren, data_wen, data_wben, read_data_reg_en, evict_addr_reg_en,
           memreq_addr_sel, way_wen, way_sel,
    output tag_match, req_index, req_word, req_type
  );

endinterface

`default_nettype wire

// File: cache_meta.sv
//------------------------------------------------------------
// Valid, dirty and LRU bits for two ways. Combinational read,
// writes at the edge into the hit way, else into the victim
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_meta #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [$clog2(num_sets)-1:0]  index,
  input  logic [1:0]                   tag_match,
  input  logic                         wen_valid,
  input  logic                         wen_dirty,
  input  logic                         dirty_in,
  input  logic                         lru_en,
  output logic                         hit,
  output logic                         hit_way,
  output logic                         victim_way,
  output logic                         victim_dirty
);

  logic [1:0][num_sets-1:0] valid;
  logic [1:0][num_sets-1:0] dirty;
  logic [num_sets-1:0]      lru;      // Per set, the way to replace next

  logic [1:0] valid_rd;
  logic [1:0] hit_vec;
  logic       wr_way;

  assign valid_rd = {valid[1][index], valid[0][index]};
  assign hit_vec  = valid_rd & tag_match;

  assign hit          = |hit_vec;
  assign hit_way      = hit_vec[1];
  assign victim_way   = lru[index];
  assign victim_dirty = valid_rd[victim_way] & dirty[victim_way][index];

  // After a refill the new line hits, so updates follow it
  assign wr_way = hit ? hit_way : victim_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (wen_valid)
        valid[wr_way][index] <= 1'b1;
      if (wen_dirty)
        dirty[wr_way][index] <= dirty_in;
      if (lru_en)
        lru[index] <= ~wr_way;  // Other way becomes the LRU
    end
  end

  // A tag lives in one way only; a double hit means a bad refill
  one_way_hit: assert property (@(posedge clk) disable iff (reset) !(&hit_vec))
    else $error("both ways hit in set %0d", index);

endmodule

`default_nettype wire

// File: cache_ctrl.sv
//------------------------------------------------------------
// Blocking cache FSM. One request in flight; a dirty victim
// is written back before the refill read is issued
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cachereq_val,
  output logic                  cachereq_rdy,
  output logic                  cacheresp_val,
  input  logic                  cacheresp_rdy,
  output logic                  memreq_val,
  input  logic                  memreq_rdy,
  input  logic                  memresp_val,
  output logic                  memresp_rdy,
  output cache_pkg::req_type_t  memreq_type,
  output logic                  cacheresp_hit,
  cache_ctrl_if.ctrl            bus
);

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t state_next;

  logic [20:0] cs;          // One row of the control table
  logic        mem_write;
  logic        wen_valid;
  logic        wen_dirty;
  logic        dirty_in;
  logic        lru_en;
  logic        hit_en;
  logic        wben_all;

  logic hit;
  logic hit_way;
  logic victim_way;
  logic victim_dirty;
  logic hit_reg;
  logic is_write;

  assign is_write = (bus.req_type == cache_pkg::REQ_WRITE);

  cache_meta #(.num_sets(num_sets)) u_meta (
    .clk          (clk),
    .reset        (reset),
    .index        (bus.req_index),
    .tag_match    (bus.tag_match),
    .wen_valid    (wen_valid),
    .wen_dirty    (wen_dirty),
    .dirty_in     (dirty_in),
    .lru_en       (lru_en),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= cache_pkg::idle;
      hit_reg <= 1'b0;
    end else begin
      state <= state_next;
      if (hit_en)
        hit_reg <= hit;
    end
  end

  assign cacheresp_hit = hit_reg;

  //------------------------------------------------------------
  // Next state
  //------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::idle:           if (cachereq_val) state_next = cache_pkg::tag_check;
      cache_pkg::tag_check: begin
        if (hit)
          state_next = is_write ? cache_pkg::write_access : cache_pkg::read_access;
        else if (victim_dirty)
          state_next = cache_pkg::evict_prepare;
        else
          state_next = cache_pkg::refill_request;
      end
      cache_pkg::read_access:    state_next = cache_pkg::wait_resp;
      cache_pkg::write_access:   state_next = cache_pkg::wait_resp;
      cache_pkg::evict_prepare:  state_next = cache_pkg::evict_request;
      cache_pkg::evict_request:  if (memreq_rdy) state_next = cache_pkg::evict_wait;
      cache_pkg::evict_wait:     if (memresp_val) state_next = cache_pkg::refill_request;
      cache_pkg::refill_request: if (memreq_rdy) state_next = cache_pkg::refill_wait;
      cache_pkg::refill_wait:    if (memresp_val) state_next = cache_pkg::refill_update;
      cache_pkg::refill_update:
        state_next = is_write ? cache_pkg::write_access : cache_pkg::read_access;
      cache_pkg::wait_resp:      if (cacheresp_rdy) state_next = cache_pkg::idle;
      default:                   state_next = cache_pkg::idle;
    endcase
  end

  //------------------------------------------------------------
  // Control table
  //------------------------------------------------------------
  // Columns, left to right:
  //   creq_rdy cresp_val mreq_val mresp_rdy _ req_en mresp_en wdata_sel
  //   tag_ren tag_wen data_ren data_wen rdata_en _ evict_en maddr_sel
  //   mem_write _ wen_valid wen_dirty dirty_in lru_en hit_en wben_all
  always_comb begin
    case (state)
      cache_pkg::idle:           cs = 21'b1000_10000000_000_000000;
      cache_pkg::tag_check:      cs = 21'b0000_00010000_000_000010;
      cache_pkg::read_access:    cs = 21'b0000_00010101_000_000100;
      cache_pkg::write_access:   cs = 21'b0000_00010010_000_011100;
      cache_pkg::evict_prepare:  cs = 21'b0000_00010101_100_000000;
      cache_pkg::evict_request:  cs = 21'b0010_00000000_011_000000;
      cache_pkg::evict_wait:     cs = 21'b0001_00000000_000_000000;
      cache_pkg::refill_request: cs = 21'b0010_00000000_000_000000;
      cache_pkg::refill_wait:    cs = 21'b0001_01000000_000_000000;
      cache_pkg::refill_update:  cs = 21'b0000_00111010_000_110001;
      cache_pkg::wait_resp:      cs = 21'b0100_00000000_000_000000;
      default:                   cs = '0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          bus.req_reg_en, bus.memresp_reg_en, bus.write_data_sel,
          bus.tag_ren, bus.tag_wen, bus.data_ren, bus.data_wen, bus.read_data_reg_en,
          bus.evict_addr_reg_en, bus.memreq_addr_sel, mem_write,
          wen_valid, wen_dirty, dirty_in, lru_en, hit_en, wben_all} = cs;

  assign memreq_type = mem_write ? cache_pkg::REQ_WRITE : cache_pkg::REQ_READ;

  // Refill writes the whole line, a store only its word
  always_comb begin
    if (!bus.data_wen)
      bus.data_wben = '0;
    else if (wben_all)
      bus.data_wben = '1;
    else
      bus.data_wben = cache_pkg::wben_t'(16'h000F) << {bus.req_word, 2'b00};
  end

  // Hit picks its own way; a miss evicts and refills the LRU way
  assign bus.way_sel = hit ? hit_way : victim_way;
  assign bus.way_wen = (bus.tag_wen | bus.data_wen) ?
                       (bus.way_sel ? 2'b10 : 2'b01) : 2'b00;

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
                                memreq_val && !memreq_rdy |=> memreq_val)
    else $error("memreq_val dropped before transfer");

endmodule

`default_nettype wire

// File: cache_way.sv
//------------------------------------------------------------
// One way of tag and data storage. Reads are combinational,
// no reset on the arrays; valid bits live in cache_meta
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                         clk,
  input  logic [$clog2(num_sets)-1:0]  index,
  input  cache_pkg::tag_t              tag_in,
  input  logic                         tag_wen,
  input  logic                         data_wen,
  input  cache_pkg::wben_t             wben,
  input  cache_pkg::line_t             data_in,
  output cache_pkg::tag_t              tag_out,
  output cache_pkg::line_t             data_out,
  output logic                         match
);

  cache_pkg::tag_t  tag_mem  [num_sets];
  cache_pkg::line_t data_mem [num_sets];

  assign tag_out  = tag_mem[index];
  assign data_out = data_mem[index];
  assign match    = (tag_out == tag_in);  // Same-cycle compare

  always_ff @(posedge clk) begin
    if (tag_wen)
      tag_mem[index] <= tag_in;
  end

  // Byte-masked line write
  always_ff @(posedge clk) begin
    if (data_wen) begin
      for (int b = 0; b < $bits(cache_pkg::wben_t); b++) begin
        if (wben[b])
          data_mem[index][b*8 +: 8] <= data_in[b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: cache_dpath.sv
//------------------------------------------------------------
// Request and refill registers, two ways, evict address and
// response word select. Write responses carry zero data
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_dpath #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::req_type_t  cachereq_type,
  input  cache_pkg::addr_t      cachereq_addr,
  input  cache_pkg::word_t      cachereq_data,
  input  cache_pkg::line_t      memresp_data,
  output cache_pkg::addr_t      memreq_addr,
  output cache_pkg::line_t      memreq_data,
  output cache_pkg::req_type_t  cacheresp_type,
  output cache_pkg::word_t      cacheresp_data,
  cache_ctrl_if.dpath           bus
);

  localparam int INDEX_BITS = $clog2(num_sets);
  localparam int OB         = cache_pkg::OFFSET_BITS;

  cache_pkg::addr_t      req_addr;
  cache_pkg::word_t      req_data;
  cache_pkg::req_type_t  req_type;
  cache_pkg::line_t      refill_line;
  cache_pkg::line_t      read_line;     // Response and writeback source
  cache_pkg::addr_t      evict_addr;
  cache_pkg::line_t      write_line;
  cache_pkg::tag_t       req_tag;

  cache_pkg::tag_t       way_tag  [2];
  cache_pkg::line_t      way_line [2];
  logic [1:0]            way_match;
  logic [INDEX_BITS-1:0] index;

  // Type steers the FSM, so it starts from a known value
  always_ff @(posedge clk) begin
    if (reset)
      req_type <= cache_pkg::REQ_READ;
    else if (bus.req_reg_en)
      req_type <= cachereq_type;
  end

  always_ff @(posedge clk) begin
    if (bus.req_reg_en) begin
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
    if (bus.memresp_reg_en)
      refill_line <= memresp_data;
    if (bus.read_data_reg_en && bus.data_ren)
      read_line <= way_line[bus.way_sel];
    if (bus.evict_addr_reg_en)
      evict_addr <= {way_tag[bus.way_sel], {OB{1'b0}}};
  end

  assign req_tag = req_addr[$bits(cache_pkg::addr_t)-1:OB];
  assign index   = req_addr[OB +: INDEX_BITS];

  // Store word copied into all slots, byte enables pick one
  assign write_line = bus.write_data_sel ? refill_line : {4{req_data}};

  for (genvar w = 0; w < 2; w++) begin : g_way
    cache_way #(.num_sets(num_sets)) u_way (
      .clk      (clk),
      .index    (index),
      .tag_in   (req_tag),
      .tag_wen  (bus.tag_wen & bus.way_wen[w]),
      .data_wen (bus.data_wen & bus.way_wen[w]),
      .wben     (bus.data_wben),
      .data_in  (write_line),
      .tag_out  (way_tag[w]),
      .data_out (way_line[w]),
      .match    (way_match[w])
    );
  end

  //------------------------------------------------------------
  // Status back to the controller and outputs
  //------------------------------------------------------------
  assign bus.tag_match = bus.tag_ren ? way_match : 2'b00;
  assign bus.req_index = index;
  assign bus.req_word  = req_addr[OB-1:2];
  assign bus.req_type  = req_type;

  assign memreq_addr = bus.memreq_addr_sel ? evict_addr : {req_tag, {OB{1'b0}}};
  assign memreq_data = read_line;

  assign cacheresp_type = req_type;
  assign cacheresp_data = (req_type == cache_pkg::REQ_WRITE) ? '0 :
                          read_line[bus.req_word*$bits(cache_pkg::word_t) +:
                                    $bits(cache_pkg::word_t)];

endmodule

`default_nettype wire

// File: blocking_cache.sv
//------------------------------------------------------------
// Two-way write-back blocking cache, 256 bytes by default.
// All four ports are val/rdy; one request in flight
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module blocking_cache #(
  parameter int num_sets = cache_pkg::DEFAULT_NUM_SETS  // Power of two, 2 or more
) (
  input  logic                  clk,
  input  logic                  reset,

  input  logic                  cachereq_val,
  output logic                  cachereq_rdy,
  input  cache_pkg::req_type_t  cachereq_type,
  input  cache_pkg::addr_t      cachereq_addr,
  input  cache_pkg::word_t      cachereq_data,

  output logic                  cacheresp_val,
  input  logic                  cacheresp_rdy,
  output cache_pkg::req_type_t  cacheresp_type,
  output cache_pkg::word_t      cacheresp_data,
  output logic                  cacheresp_hit,

  output logic                  memreq_val,
  input  logic                  memreq_rdy,
  output cache_pkg::req_type_t  memreq_type,
  output cache_pkg::addr_t      memreq_addr,
  output cache_pkg::line_t      memreq_data,

  input  logic                  memresp_val,
  output logic                  memresp_rdy,
  input  cache_pkg::line_t      memresp_data
);

  cache_ctrl_if #(.num_sets(num_sets)) bus ();

  cache_ctrl #(.num_sets(num_sets)) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memreq_type   (memreq_type),
    .cacheresp_hit (cacheresp_hit),
    .bus           (bus)
  );

  cache_dpath #(.num_sets(num_sets)) u_dpath (
    .clk            (clk),
    .reset          (reset),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .memresp_data   (memresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .bus            (bus)
  );

endmodule

`default_nettype wire

// File: cache_checker.sv
//------------------------------------------------------------
// Reference two-way LRU cache over a flat word memory.
// Only addresses below mem_words*4 bytes are modelled
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_checker #(
  parameter int num_sets  = cache_pkg::DEFAULT_NUM_SETS,
  parameter int mem_words = 128
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cachereq_val,
  input  logic                  cachereq_rdy,
  input  cache_pkg::req_type_t  cachereq_type,
  input  cache_pkg::addr_t      cachereq_addr,
  input  cache_pkg::word_t      cachereq_data,
  input  logic                  cacheresp_val,
  input  logic                  cacheresp_rdy,
  input  cache_pkg::req_type_t  cacheresp_type,
  input  cache_pkg::word_t      cacheresp_data,
  input  logic                  cacheresp_hit,
  input  logic                  memreq_val,
  input  logic                  memreq_rdy,
  input  cache_pkg::req_type_t  memreq_type,
  input  cache_pkg::addr_t      memreq_addr,
  input  cache_pkg::line_t      memreq_data,
  input  logic                  memresp_val,
  input  logic                  memresp_rdy,
  output int                    errors,
  output int                    checks
);

  localparam int OB = cache_pkg::OFFSET_BITS;
  localparam int IB = $clog2(num_sets);

  cache_pkg::word_t         words [mem_words];  // Latest value of every word
  cache_pkg::tag_t          tags  [2][num_sets];
  logic [1:0][num_sets-1:0] valid;
  logic [1:0][num_sets-1:0] dirty;
  logic [num_sets-1:0]      lru;                // Way to replace next

  logic                 busy;
  logic                 exp_hit;
  logic                 exp_wb;
  logic                 exp_refill;
  logic                 val_seen;
  logic                 was_reset;
  logic                 mreq_stall;
  logic                 mem_pending;            // Memory request awaiting its response
  cache_pkg::req_type_t exp_type;
  cache_pkg::word_t     exp_data;
  cache_pkg::addr_t     wb_addr;
  cache_pkg::addr_t     refill_addr;
  cache_pkg::addr_t     held_addr;
  cache_pkg::line_t     wb_line;
  int                   cycle;
  int                   accept_cycle;

  function automatic cache_pkg::word_t initial_word(cache_pkg::addr_t a);
    return (a * 32'h9E3779B1) ^ 32'hA5A5A5A5;
  endfunction

  function automatic int word_slot(cache_pkg::addr_t a);
    return int'((a >> 2) % mem_words);
  endfunction

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic protocol_error(input string what);
    errors++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    for (int i = 0; i < mem_words; i++)
      words[i] = initial_word(cache_pkg::addr_t'(i * 4));
  end

  //------------------------------------------------------------
  // Reference cache update at acceptance
  //------------------------------------------------------------
  task automatic accept_request();
    int              idx;
    int              way;
    cache_pkg::tag_t tag;
    idx = int'(cachereq_addr[OB +: IB]);
    tag = cachereq_addr[$bits(cache_pkg::addr_t)-1:OB];
    way = int'(lru[idx]);
    exp_hit = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (valid[w][idx] && tags[w][idx] == tag) begin
        exp_hit = 1'b1;
        way = w;
      end
    end
    exp_wb     = !exp_hit && valid[way][idx] && dirty[way][idx];  // Dirty victim only
    exp_refill = !exp_hit;
    wb_addr    = {tags[way][idx], {OB{1'b0}}};
    for (int k = 0; k < 4; k++)
      wb_line[k*32 +: 32] = words[word_slot(wb_addr + 4*k)];
    refill_addr = {tag, {OB{1'b0}}};
    if (!exp_hit) begin
      tags[way][idx]  = tag;
      valid[way][idx] = 1'b1;
      dirty[way][idx] = 1'b0;
    end
    if (cachereq_type == cache_pkg::REQ_WRITE) begin
      words[word_slot(cachereq_addr)] = cachereq_data;
      dirty[way][idx] = 1'b1;
      exp_data = '0;
    end else begin
      exp_data = words[word_slot(cachereq_addr)];
    end
    lru[idx]     = (way == 0);
    exp_type     = cachereq_type;
    busy         = 1'b1;
    val_seen     = 1'b0;
    accept_cycle = cycle;
  endtask

  task automatic memory_request();
    if (memreq_type == cache_pkg::REQ_WRITE) begin
      if (!exp_wb) begin
        protocol_error("memory write without a dirty victim");
      end else begin
        compare("writeback address", memreq_addr, wb_addr);
        compare("writeback data", memreq_data, wb_line);
        exp_wb = 1'b0;
      end
    end else if (exp_wb || !exp_refill) begin
      protocol_error("memory read issued out of order");
    end else begin
      compare("refill address", memreq_addr, refill_addr);
      exp_refill = 1'b0;
    end
  endtask

  task automatic finish_response();
    compare("response hit flag", cacheresp_hit, exp_hit);
    compare("response type", cacheresp_type, exp_type);
    compare("response data", cacheresp_data, exp_data);
    if (exp_wb || exp_refill || mem_pending)
      protocol_error("response sent before the line was refilled");
    busy = 1'b0;
  endtask

  // Transfers are taken from the values just before each edge
  always @(posedge clk) begin
    if (reset) begin
      valid       = '0;
      dirty       = '0;
      lru         = '0;
      busy        = 1'b0;
      exp_wb      = 1'b0;
      exp_refill  = 1'b0;
      mreq_stall  = 1'b0;
      mem_pending = 1'b0;
      cycle       = 0;
      was_reset   = 1'b1;
    end else begin
      cycle++;
      if (was_reset && (cacheresp_val || memreq_val || memresp_rdy))
        protocol_error("valid or ready output high right after reset");
      was_reset = 1'b0;
      if (mreq_stall && (!memreq_val || memreq_addr !== held_addr))
        protocol_error("memory request changed before it was accepted");
      mreq_stall = memreq_val && !memreq_rdy;
      held_addr  = memreq_addr;
      if (memresp_rdy && !mem_pending)
        protocol_error("memresp_rdy high with no memory request outstanding");
      if (memresp_val && memresp_rdy)
        mem_pending = 1'b0;
      if (cacheresp_val && !busy)
        protocol_error("response with no request in flight");
      if (cacheresp_val && busy && !val_seen) begin
        val_seen = 1'b1;
        if (exp_hit)
          compare("hit latency in cycles", cycle - accept_cycle, 3);
      end
      if (memreq_val && memreq_rdy) begin
        if (mem_pending)
          protocol_error("memory request issued before the previous response");
        mem_pending = 1'b1;
        memory_request();
      end
      if (cacheresp_val && cacheresp_rdy && busy)
        finish_response();
      if (cachereq_val && cachereq_rdy) begin
        if (busy)
          protocol_error("request accepted while another is in flight");
        accept_request();
      end
    end
  end

endmodule

`default_nettype wire

// File: cache_tb.sv
//------------------------------------------------------------
// Random requests over a 512-byte pool on four sets.
// Memory model answers one request at a time
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

  localparam int NUM_SETS   = cache_pkg::DEFAULT_NUM_SETS;
  localparam int PHASE_REQS = 150;
  localparam int TOTAL_REQS = 2 * PHASE_REQS;
  localparam int CLK_PERIOD = 10;
  localparam int MEM_LINES  = 32;

  logic                 clk;
  logic                 reset;
  logic                 cachereq_val;
  logic                 cachereq_rdy;
  cache_pkg::req_type_t cachereq_type;
  cache_pkg::addr_t     cachereq_addr;
  cache_pkg::word_t     cachereq_data;
  logic                 cacheresp_val;
  logic                 cacheresp_rdy;
  cache_pkg::req_type_t cacheresp_type;
  cache_pkg::word_t     cacheresp_data;
  logic                 cacheresp_hit;
  logic                 memreq_val;
  logic                 memreq_rdy;
  cache_pkg::req_type_t memreq_type;
  cache_pkg::addr_t     memreq_addr;
  cache_pkg::line_t     memreq_data;
  logic                 memresp_val;
  logic                 memresp_rdy;
  cache_pkg::line_t     memresp_data;

  int               errors;
  int               checks;
  int               seed;
  int               requests;
  bit               pressure;                // Random stalls on all ports
  cache_pkg::line_t mem [MEM_LINES];

  blocking_cache #(.num_sets(NUM_SETS)) UUT (.*);

  cache_checker #(.num_sets(NUM_SETS), .mem_words(MEM_LINES * 4)) chk (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic cache_pkg::word_t initial_word(cache_pkg::addr_t a);
    return (a * 32'h9E3779B1) ^ 32'hA5A5A5A5;
  endfunction

  // Four tags on four sets, so 16 lines fight for 8 slots
  function automatic cache_pkg::addr_t pick_address();
    logic [31:0] r;
    r = $random(seed);
    return {23'd0, r[8:7], 1'b0, r[5:4], r[3:2], 2'b00};
  endfunction

  // Starts and ends on a falling edge
  task automatic run_request();
    logic done;
    if (pressure)
      repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    cachereq_val  = 1'b1;
    cachereq_type = ($random(seed) % 2 == 0) ? cache_pkg::REQ_READ : cache_pkg::REQ_WRITE;
    cachereq_addr = pick_address();
    cachereq_data = $random(seed);
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cacheresp_rdy = !pressure || ($random(seed) % 2 == 0);
      done = cacheresp_val && cacheresp_rdy;  // Transfer on the next edge
    end
    @(negedge clk);
    requests++;
  endtask

  task automatic run_phase(input string name, input bit stall);
    int start_errors;
    start_errors  = errors;
    pressure      = stall;
    cacheresp_rdy = 1'b1;
    for (int n = 0; n < PHASE_REQS; n++)
      run_request();
    $display("Test %s: %0d requests, %0d new errors", name, PHASE_REQS,
             errors - start_errors);
  endtask

  //------------------------------------------------------------
  // Memory model
  //------------------------------------------------------------
  initial begin : memory_port
    logic             write;
    cache_pkg::addr_t addr;
    cache_pkg::line_t data;
    int               delay;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    for (int l = 0; l < MEM_LINES; l++)
      for (int k = 0; k < 4; k++)
        mem[l][k*32 +: 32] = initial_word(cache_pkg::addr_t'(l * 16 + k * 4));
    forever begin
      @(negedge clk);
      memreq_rdy = !pressure || ($random(seed) % 2 == 0);
      if (memreq_val && memreq_rdy) begin
        write = (memreq_type == cache_pkg::REQ_WRITE);
        addr  = memreq_addr;
        data  = memreq_data;
        @(negedge clk);
        memreq_rdy = 1'b0;
        if (write)
          mem[addr[8:4]] = data;
        delay = pressure ? $unsigned($random(seed)) % 5 : 0;
        repeat (delay) @(negedge clk);
        memresp_data = write ? '0 : mem[addr[8:4]];
        memresp_val  = 1'b1;
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(TOTAL_REQS * 200 * CLK_PERIOD);
    $display("Timeout: requests did not complete within %0d cycles", TOTAL_REQS * 200);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    seed          = 32'h2f8ceaf1;
    requests      = 0;
    pressure      = 1'b0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = cache_pkg::REQ_READ;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    run_phase("random mix, ports always ready", 1'b0);
    run_phase("random mix, random back-pressure", 1'b1);
    $display("Summary: %0d requests, %0d checks, %0d errors", requests, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
cache_pkg.sv
cache_ctrl_if.sv
cache_meta.sv
cache_ctrl.sv
cache_way.sv
cache_dpath.sv
blocking_cache.sv
cache_checker.sv
cache_tb.sv

// File: Bender.yml
package:
  name: blocking_cache

sources:
  - cache_pkg.sv
  - cache_ctrl_if.sv
  - cache_meta.sv
  - cache_ctrl.sv
  - cache_way.sv
  - cache_dpath.sv
  - blocking_cache.sv
  - target: simulation
    files:
      - cache_checker.sv
      - cache_tb.sv
